/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_address_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [4:0]  sub_opcode_t;

  typedef enum logic [1:0] {
    stop_state    = 2'b00,
    fetch_state   = 2'b01,
    execute_state = 2'b10,
    write_state   = 2'b11
  } control_state_t;

  // immediate extension modes
  typedef enum logic [1:0] {
    imm5_zero  = 2'b00,
    imm15_sign = 2'b01,
    imm15_zero = 2'b10,
    imm20_sign = 2'b11
  } imm_kind_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_rotr
  } alu_op_t;

  // major opcodes, instruction bits 30:25
  localparam opcode_t op_alu  = 6'b100000;
  localparam opcode_t op_addi = 6'b101000;
  localparam opcode_t op_ori  = 6'b101100;
  localparam opcode_t op_xori = 6'b101011;
  localparam opcode_t op_movi = 6'b100010;

  // function field of the alu group, bits 4:0
  localparam sub_opcode_t sub_add   = 5'b00000;
  localparam sub_opcode_t sub_sub   = 5'b00001;
  localparam sub_opcode_t sub_and   = 5'b00010;
  localparam sub_opcode_t sub_xor   = 5'b00011;
  localparam sub_opcode_t sub_or    = 5'b00100;
  localparam sub_opcode_t sub_slli  = 5'b01000;
  localparam sub_opcode_t sub_srli  = 5'b01001;
  localparam sub_opcode_t sub_rotri = 5'b01011;

endpackage

`default_nettype wire

/* source/regfile_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface regfile_if;
  import cpu_pkg::*;

  reg_address_t read_address1;
  reg_address_t read_address2;
  reg_address_t write_address;
  logic         read_enable;
  logic         write_enable;
  word_t        read_data1;
  word_t        read_data2;
  word_t        write_data;

  // addresses and enables come from the decoded instruction
  modport control (
    output read_address1,
    output read_address2,
    output write_address,
    output read_enable,
    output write_enable
  );

  modport datapath (
    input  read_data1,
    input  read_data2,
    output write_data
  );

  modport storage (
    input  read_address1,
    input  read_address2,
    input  write_address,
    input  read_enable,
    input  write_enable,
    input  write_data,
    output read_data1,
    output read_data2
  );

endinterface

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
  parameter int mem_address_width = 10
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         load_enable,
  input  logic [mem_address_width-1:0] load_address,
  input  cpu_pkg::word_t               load_data,
  input  logic                         retire,
  output logic [mem_address_width-1:0] pc,
  output cpu_pkg::word_t               instruction
);
  import cpu_pkg::*;

  localparam int mem_depth = 2 ** mem_address_width;

  word_t memory [mem_depth];

  // loaded only while the core sits in stop
  always_ff @(posedge clock) begin
    if (load_enable) begin
      memory[load_address] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (retire) begin
      pc <= pc + 1'b1;
    end
  end

  assign instruction = memory[pc];

endmodule

`default_nettype wire

/* source/ir_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module ir_controller (
  input  logic               clock,
  input  logic               reset,
  input  logic               run,
  input  cpu_pkg::word_t     instruction,
  regfile_if.control         regs,
  output cpu_pkg::imm_kind_t imm_kind,
  output logic               imm_reg_select,
  output logic               writeback_select,
  output logic               execute_enable,
  output logic               retire,
  output cpu_pkg::alu_op_t   alu_op,
  output logic [19:0]        immediate
);
  import cpu_pkg::*;

  control_state_t state;
  control_state_t next_state;
  word_t          present_instruction;
  opcode_t        opcode;
  sub_opcode_t    sub_opcode;
  logic           is_shift;

  assign opcode     = present_instruction[30:25];
  assign sub_opcode = present_instruction[4:0];
  assign immediate  = present_instruction[19:0];

  assign regs.write_address = present_instruction[24:20];
  assign regs.read_address1 = present_instruction[19:15];
  assign regs.read_address2 = present_instruction[14:10];

  // stop holds until run, the rest always advance
  always_comb begin
    case (state)
      stop_state:    next_state = run ? fetch_state : stop_state;
      fetch_state:   next_state = execute_state;
      execute_state: next_state = write_state;
      default:       next_state = stop_state;
    endcase
  end

  // enables registered from the next state so they line up with it
  always_ff @(posedge clock) begin
    if (reset) begin
      state             <= stop_state;
      regs.read_enable  <= 1'b0;
      execute_enable    <= 1'b0;
      regs.write_enable <= 1'b0;
      retire            <= 1'b0;
    end else begin
      state             <= next_state;
      regs.read_enable  <= (next_state == fetch_state);
      execute_enable    <= (next_state == execute_state);
      regs.write_enable <= (next_state == write_state);
      retire            <= (next_state == write_state);
    end
  end

  // latch on the edge leaving stop
  always_ff @(posedge clock) begin
    if (state == stop_state && next_state == fetch_state) begin
      present_instruction <= instruction;
    end
  end

  assign is_shift = (sub_opcode == sub_slli) || (sub_opcode == sub_srli) ||
                    (sub_opcode == sub_rotri);

  assign writeback_select = (opcode == op_movi);

  always_comb begin
    imm_kind       = imm5_zero;
    imm_reg_select = 1'b0;
    alu_op         = alu_add;
    case (opcode)
      op_alu: begin
        imm_reg_select = is_shift;
        case (sub_opcode)
          sub_sub:   alu_op = alu_sub;
          sub_and:   alu_op = alu_and;
          sub_or:    alu_op = alu_or;
          sub_xor:   alu_op = alu_xor;
          sub_slli:  alu_op = alu_sll;
          sub_srli:  alu_op = alu_srl;
          sub_rotri: alu_op = alu_rotr;
          default:   alu_op = alu_add;
        endcase
      end
      op_addi: begin
        imm_kind       = imm15_sign;
        imm_reg_select = 1'b1;
      end
      op_ori: begin
        imm_kind       = imm15_zero;
        imm_reg_select = 1'b1;
        alu_op         = alu_or;
      end
      op_xori: begin
        imm_kind       = imm15_zero;
        imm_reg_select = 1'b1;
        alu_op         = alu_xor;
      end
      // alu result ignored, operand 2 is written back
      op_movi: begin
        imm_kind       = imm20_sign;
        imm_reg_select = 1'b1;
      end
      default: begin
        imm_kind = imm5_zero;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic                  clock,
  input  logic                  reset,
  regfile_if.storage            regs,
  input  cpu_pkg::reg_address_t debug_address,
  output cpu_pkg::word_t        debug_data
);
  import cpu_pkg::*;

  localparam int reg_count = 2 ** $bits(reg_address_t);

  word_t storage [reg_count];

  // r0 is an ordinary register here
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        storage[i] <= '0;
      end
    end else if (regs.write_enable) begin
      storage[regs.write_address] <= regs.write_data;
    end
  end

  // operands captured at the end of fetch
  always_ff @(posedge clock) begin
    if (regs.read_enable) begin
      regs.read_data1 <= storage[regs.read_address1];
      regs.read_data2 <= storage[regs.read_address2];
    end
  end

  assign debug_data = storage[debug_address];

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
  input  logic               clock,
  input  logic               reset,
  regfile_if.datapath        regs,
  input  cpu_pkg::imm_kind_t imm_kind,
  input  logic               imm_reg_select,
  input  logic               writeback_select,
  input  cpu_pkg::alu_op_t   alu_op,
  input  logic [19:0]        immediate,
  input  logic               execute_enable
);
  import cpu_pkg::*;

  word_t       extended_imm;
  word_t       operand1;
  word_t       operand2;
  word_t       alu_result;
  word_t       result;
  logic [4:0]  shift_amount;
  logic [63:0] rotate_wide;

  always_comb begin
    case (imm_kind)
      imm5_zero:  extended_imm = {27'd0, immediate[14:10]};
      imm15_sign: extended_imm = {{17{immediate[14]}}, immediate[14:0]};
      imm15_zero: extended_imm = {17'd0, immediate[14:0]};
      default:    extended_imm = {{12{immediate[19]}}, immediate};
    endcase
  end

  assign operand1     = regs.read_data1;
  assign operand2     = imm_reg_select ? extended_imm : regs.read_data2;
  assign shift_amount = operand2[4:0];

  // doubled word, low half is the rotate
  assign rotate_wide = {operand1, operand1} >> shift_amount;

  always_comb begin
    case (alu_op)
      alu_add: alu_result = operand1 + operand2;
      alu_sub: alu_result = operand1 - operand2;
      alu_and: alu_result = operand1 & operand2;
      alu_or:  alu_result = operand1 | operand2;
      alu_xor: alu_result = operand1 ^ operand2;
      alu_sll: alu_result = operand1 << shift_amount;
      alu_srl: alu_result = operand1 >> shift_amount;
      default: alu_result = rotate_wide[31:0];
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (execute_enable) begin
      result <= writeback_select ? operand2 : alu_result;
    end
  end

  assign regs.write_data = result;

endmodule

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
  parameter int mem_address_width = 10
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         run,
  input  logic                         load_enable,
  input  logic [mem_address_width-1:0] load_address,
  input  cpu_pkg::word_t               load_data,
  input  cpu_pkg::reg_address_t        debug_address,
  output cpu_pkg::word_t               debug_data,
  output logic [mem_address_width-1:0] pc,
  output logic                         retire
);

  cpu_pkg::word_t     instruction;
  cpu_pkg::imm_kind_t imm_kind;
  cpu_pkg::alu_op_t   alu_op;
  logic               imm_reg_select;
  logic               writeback_select;
  logic               execute_enable;
  logic [19:0]        immediate;

  regfile_if regs ();

  fetch_unit #(
    .mem_address_width(mem_address_width)
  ) u_fetch (
    .clock       (clock),
    .reset       (reset),
    .load_enable (load_enable),
    .load_address(load_address),
    .load_data   (load_data),
    .retire      (retire),
    .pc          (pc),
    .instruction (instruction)
  );

  ir_controller u_controller (
    .clock           (clock),
    .reset           (reset),
    .run             (run),
    .instruction     (instruction),
    .regs            (regs.control),
    .imm_kind        (imm_kind),
    .imm_reg_select  (imm_reg_select),
    .writeback_select(writeback_select),
    .execute_enable  (execute_enable),
    .retire          (retire),
    .alu_op          (alu_op),
    .immediate       (immediate)
  );

  register_file u_register_file (
    .clock        (clock),
    .reset        (reset),
    .regs         (regs.storage),
    .debug_address(debug_address),
    .debug_data   (debug_data)
  );

  execute_unit u_execute (
    .clock           (clock),
    .reset           (reset),
    .regs            (regs.datapath),
    .imm_kind        (imm_kind),
    .imm_reg_select  (imm_reg_select),
    .writeback_select(writeback_select),
    .alu_op          (alu_op),
    .immediate       (immediate),
    .execute_enable  (execute_enable)
  );

endmodule

`default_nettype wire

/* tests/cpu_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_assertions (
  input logic                    clock,
  input logic                    reset,
  input cpu_pkg::control_state_t state,
  input logic                    read_enable,
  input logic                    execute_enable,
  input logic                    write_enable,
  input logic                    retire
);
  import cpu_pkg::*;

  int failure_count = 0;

  // one enable per active state, none in stop
  assert property (@(posedge clock) disable iff (reset)
    {read_enable, execute_enable, write_enable} ==
    {state == fetch_state, state == execute_state, state == write_state})
  else begin
    failure_count++;
    $error("enables do not follow the state");
  end

  // four states in a fixed ring where stop may hold
  assert property (@(posedge clock) disable iff (reset)
    (state == fetch_state) |=> (state == execute_state))
  else begin
    failure_count++;
    $error("fetch not followed by execute");
  end

  assert property (@(posedge clock) disable iff (reset)
    (state == execute_state) |=> (state == write_state))
  else begin
    failure_count++;
    $error("execute not followed by write");
  end

  assert property (@(posedge clock) disable iff (reset)
    (state == write_state) |=> (state == stop_state))
  else begin
    failure_count++;
    $error("write not followed by stop");
  end

  assert property (@(posedge clock) disable iff (reset)
    (state == stop_state) |=> (state == stop_state || state == fetch_state))
  else begin
    failure_count++;
    $error("stop left for a state other than fetch");
  end

  assert property (@(posedge clock) disable iff (reset) retire == (state == write_state))
  else begin
    failure_count++;
    $error("retire outside the write state");
  end

  assert property (@(posedge clock)
    reset |=> !(read_enable || execute_enable || write_enable || retire))
  else begin
    failure_count++;
    $error("enables not cleared by reset");
  end

endmodule

bind ir_controller cpu_assertions u_assertions (
  .clock         (clock),
  .reset         (reset),
  .state         (state),
  .read_enable   (regs.read_enable),
  .execute_enable(execute_enable),
  .write_enable  (regs.write_enable),
  .retire        (retire)
);

`default_nettype wire

/* tests/cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam int aw = 10;

  logic           clock;
  logic           reset;
  logic           run;
  logic           load_enable;
  logic [aw-1:0]  load_address;
  word_t          load_data;
  reg_address_t   debug_address;
  word_t          debug_data;
  logic [aw-1:0]  pc;
  logic           retire;

  word_t          model [32];
  word_t          program_q [$];
  logic [31:0]    rng_state;
  word_t          random_word;
  int             errors;
  int             checks;
  bit             timed_out;

  cpu_top #(
    .mem_address_width(aw)
  ) u_dut (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .load_enable  (load_enable),
    .load_address (load_address),
    .load_data    (load_data),
    .debug_address(debug_address),
    .debug_data   (debug_data),
    .pc           (pc),
    .retire       (retire)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // expected alu group result with b as the shift amount for shifts
  function automatic word_t model_alu(input sub_opcode_t sub, input word_t a, input word_t b);
    int n;
    n = int'(b[4:0]);
    case (sub)
      sub_add:   return a + b;
      sub_sub:   return a - b;
      sub_and:   return a & b;
      sub_or:    return a | b;
      sub_xor:   return a ^ b;
      sub_slli:  return a << n;
      sub_srli:  return a >> n;
      sub_rotri: return (a >> n) | (a << (32 - n));
      default:   return '0;
    endcase
  endfunction

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic add_movi(input reg_address_t rd, input logic [19:0] value);
    program_q.push_back({1'b0, op_movi, rd, value});
    model[rd] = {{12{value[19]}}, value};
  endtask

  task automatic add_alu(input reg_address_t rd, input reg_address_t rs1,
                         input reg_address_t rs2, input sub_opcode_t sub);
    program_q.push_back({1'b0, op_alu, rd, rs1, rs2, 5'd0, sub});
    model[rd] = model_alu(sub, model[rs1], model[rs2]);
  endtask

  task automatic add_shift(input reg_address_t rd, input reg_address_t rs,
                           input logic [4:0] amount, input sub_opcode_t sub);
    program_q.push_back({1'b0, op_alu, rd, rs, amount, 5'd0, sub});
    model[rd] = model_alu(sub, model[rs], {27'd0, amount});
  endtask

  task automatic add_imm(input opcode_t op, input reg_address_t rd, input reg_address_t rs,
                         input logic [14:0] imm);
    word_t ext;
    program_q.push_back({1'b0, op, rd, rs, imm});
    if (op == op_addi) begin
      ext = {{17{imm[14]}}, imm};
      model[rd] = model[rs] + ext;
    end else begin
      ext = {17'd0, imm};
      model[rd] = (op == op_ori) ? (model[rs] | ext) : (model[rs] ^ ext);
    end
  endtask

  // program goes in at the present pc where the core resumes
  task automatic load_program();
    logic [aw-1:0] address;
    address = pc;
    foreach (program_q[i]) begin
      load_enable  = 1'b1;
      load_address = address;
      load_data    = program_q[i];
      @(posedge clock);
      #1;
      address++;
    end
    load_enable = 1'b0;
  endtask

  task automatic wait_retire(output int cycles);
    cycles = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
    end while (!retire && cycles < 16);
    if (!retire) begin
      timed_out = 1'b1;
      $display("timeout at %0t: no retire pulse within %0d cycles", $time, cycles);
    end
  endtask

  task automatic check_registers();
    for (int r = 0; r < 32; r++) begin
      debug_address = reg_address_t'(r);
      @(posedge clock);
      #1;
      check_value(debug_data, model[r], $sformatf("register r%0d", r));
    end
  endtask

  task automatic run_program();
    logic [aw-1:0] base;
    int            cycles;
    base = pc;
    load_program();
    run = 1'b1;
    for (int k = 0; k < program_q.size(); k++) begin
      wait_retire(cycles);
      if (timed_out) break;
      if (k > 0) check_value(word_t'(cycles), 32'd4, "cycles between retire pulses");
      check_value(word_t'(pc), word_t'(base) + word_t'(k), "pc at retire");
    end
    // dropped in write so the core settles in stop
    run = 1'b0;
    @(posedge clock);
    #1;
    check_registers();
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("test %s finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic test_movi();
    int start_errors;
    start_errors = errors;
    program_q.delete();
    check_value(word_t'(pc), 32'd0, "pc after reset");
    // odd registers get negative values
    for (int r = 0; r < 8; r++) begin
      random_word = next_random();
      add_movi(reg_address_t'(r), {r[0], random_word[18:0]});
    end
    run_program();
    report_test("movi", start_errors);
  endtask

  task automatic test_register_alu();
    int start_errors;
    start_errors = errors;
    program_q.delete();
    for (int r = 10; r < 14; r++) begin
      random_word = next_random();
      add_movi(reg_address_t'(r), random_word[19:0]);
    end
    add_alu(5'd14, 5'd10, 5'd11, sub_add);
    add_alu(5'd15, 5'd10, 5'd11, sub_sub);
    add_alu(5'd16, 5'd12, 5'd13, sub_and);
    add_alu(5'd17, 5'd12, 5'd13, sub_or);
    add_alu(5'd18, 5'd10, 5'd13, sub_xor);
    add_alu(5'd19, 5'd13, 5'd12, sub_sub);
    add_alu(5'd20, 5'd14, 5'd15, sub_add);
    run_program();
    report_test("register alu", start_errors);
  endtask

  task automatic test_immediate();
    int start_errors;
    start_errors = errors;
    program_q.delete();
    // positive source so the upper bits show the extension
    random_word = next_random();
    add_movi(5'd21, {1'b0, random_word[18:0]});
    random_word = next_random();
    add_imm(op_addi, 5'd22, 5'd21, {1'b1, random_word[13:0]});
    add_imm(op_addi, 5'd23, 5'd21, {1'b0, random_word[27:14]});
    add_imm(op_ori,  5'd24, 5'd21, {1'b1, random_word[13:0]});
    add_imm(op_xori, 5'd25, 5'd21, {1'b1, random_word[27:14]});
    add_imm(op_ori,  5'd26, 5'd21, {1'b0, random_word[27:14]});
    run_program();
    report_test("immediate", start_errors);
  endtask

  task automatic test_shifts();
    logic [4:0]   amounts [4];
    sub_opcode_t  kinds [3];
    reg_address_t rd;
    int           start_errors;
    start_errors = errors;
    amounts = '{5'd0, 5'd1, 5'd17, 5'd31};
    kinds   = '{sub_slli, sub_srli, sub_rotri};
    program_q.delete();
    // full width source with the top bit set
    random_word = next_random();
    add_movi(5'd27, {1'b1, random_word[18:0]});
    random_word = next_random();
    add_movi(5'd28, random_word[19:0]);
    add_shift(5'd29, 5'd28, 5'd12, sub_slli);
    add_alu(5'd30, 5'd27, 5'd29, sub_xor);
    rd = 5'd1;
    foreach (kinds[k]) begin
      foreach (amounts[a]) begin
        add_shift(rd, 5'd30, amounts[a], kinds[k]);
        rd++;
      end
    end
    run_program();
    report_test("shifts", start_errors);
  endtask

  task automatic test_timing();
    logic [aw-1:0] held_pc;
    int            start_errors;
    start_errors = errors;
    program_q.delete();
    for (int r = 2; r < 8; r++) begin
      random_word = next_random();
      add_movi(reg_address_t'(r), random_word[19:0]);
    end
    run_program();
    held_pc = pc;
    repeat (20) begin
      @(posedge clock);
      #1;
      check_value({31'd0, retire}, 32'd0, "retire with run low");
      check_value(word_t'(pc), word_t'(held_pc), "pc with run low");
    end
    report_test("timing", start_errors);
  endtask

  initial begin
    reset         = 1'b1;
    run           = 1'b0;
    load_enable   = 1'b0;
    load_address  = '0;
    load_data     = '0;
    debug_address = '0;
    rng_state     = 32'h0d3c_8208;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    foreach (model[i]) model[i] = '0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    test_movi();
    test_register_alu();
    test_immediate();
    test_shifts();
    test_timing();
    errors += u_dut.u_controller.u_assertions.failure_count;
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, int'(timed_out));
    if (errors == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
source/cpu_pkg.sv
source/regfile_if.sv
source/fetch_unit.sv
source/ir_controller.sv
source/register_file.sv
source/execute_unit.sv
source/cpu_top.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f list.f -o cpu_sim &&
./obj_dir/cpu_sim +verilator+error+limit+100 | tee /dev/stderr | grep "=== PASS ===" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
